//--- ice_config.svh
`ifndef ICE_CONFIG_SVH
`define ICE_CONFIG_SVH

// uart timing
// one bit lasts ICE_CLKS_PER_BIT+1 clock cycles on both rx and tx
`define ICE_CLKS_PER_BIT   104

// code memory
`define ICE_CODE_DEPTH     256   // bytes loaded after reset
`define ICE_CODE_AW        8     // pc and loader address width

// movx i/o map
// status read gives tx busy in bit 0
`define ICE_TX_STAT_ADDR   16'h0200
`define ICE_TX_DATA_ADDR   16'h0201   // write starts a frame

`endif

//--- ice_pkg.sv
`default_nettype none

package ice_pkg;

   // sequencer phases
   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } seq_state_e;

   // decoded operation, register forms merged
   typedef enum logic [5:0] {
      OP_NOP,
      OP_MOV_A_IMM,
      OP_MOV_R_IMM,
      OP_MOV_A_R,
      OP_MOV_R_A,
      OP_ADD_A_IMM,
      OP_ADD_A_R,
      OP_ADDC_A_R,
      OP_SUBB_A_IMM,
      OP_SUBB_A_R,
      OP_ANL_A_IMM,
      OP_ORL_A_IMM,
      OP_XRL_A_IMM,
      OP_INC_A,
      OP_DEC_A,
      OP_INC_R,
      OP_DEC_R,
      OP_CPL_A,
      OP_CLR_A,
      OP_CLR_C,
      OP_SETB_C,
      OP_RL_A,
      OP_RLC_A,
      OP_RRC_A,
      OP_SWAP_A,
      OP_SJMP,
      OP_JZ,
      OP_JNZ,
      OP_JC,
      OP_JNC,
      OP_DJNZ_R,
      OP_MOV_DPTR,
      OP_MOVX_W,     // movx @dptr,a
      OP_MOVX_R      // movx a,@dptr
   } op_e;

   // uart phases
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

`default_nettype wire

//--- ice_uart_rx_loader.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_uart_rx_loader import ice_pkg::*; (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  wire                      i_uart_rx,
   output logic                     o_code_wr,
   output logic [`ICE_CODE_AW-1:0]  o_code_waddr,
   output logic [7:0]               o_code_wdata,
   output logic                     o_load_done
);

   localparam int BIT_CLKS = `ICE_CLKS_PER_BIT;
   localparam int CW       = $clog2(BIT_CLKS + 1);
   localparam int AW       = `ICE_CODE_AW;

   logic             rx_meta;
   logic             rx_sync;
   rx_state_e        state;
   logic [CW-1:0]    cnt;
   logic [7:0]       shreg;
   logic [AW-1:0]    waddr;
   logic             half_tick;
   logic             bit_tick;
   logic             byte_done;

   // two flop resync, line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_tick = (cnt == CW'(BIT_CLKS / 2));
   assign bit_tick  = (cnt == CW'(BIT_CLKS));
   assign byte_done = (state == RX_STOP) & bit_tick;   // middle of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + CW'(1);
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync) state <= RX_START;
            end
            RX_START: if (half_tick) begin
               cnt   <= '0;
               state <= rx_sync ? RX_IDLE : RX_DATA;   // drop short glitches
            end
            RX_DATA: if (bit_tick) begin
               cnt <= '0;
               if (shreg[0]) state <= RX_STOP;   // marker reached the bottom
            end
            RX_STOP: if (bit_tick) begin
               cnt   <= '0;
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // lsb first, marker bit tells when eight bits are in
   always_ff @(posedge i_clk) begin
      if (state == RX_START && half_tick) shreg <= 8'h80;
      else if (state == RX_DATA && bit_tick) shreg <= {rx_sync, shreg[7:1]};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         waddr       <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         waddr <= waddr + AW'(1);
         if (waddr == AW'(`ICE_CODE_DEPTH - 1)) o_load_done <= 1'b1;
      end
   end

   assign o_code_wr    = byte_done & ~o_load_done;
   assign o_code_waddr = waddr;
   assign o_code_wdata = shreg;

endmodule

`default_nettype wire

//--- ice_uart_tx.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_uart_tx import ice_pkg::*; (
   input  wire          i_clk,
   input  wire          i_nrst,
   input  wire          i_start,
   input  wire  [7:0]   i_data,
   output logic         o_busy,
   output logic         o_uart_tx
);

   localparam int BIT_CLKS = `ICE_CLKS_PER_BIT;
   localparam int CW       = $clog2(BIT_CLKS + 1);

   tx_state_e        state;
   logic [CW-1:0]    cnt;
   logic [2:0]       bitn;
   logic [7:0]       shreg;
   logic             bit_tick;

   assign bit_tick = (cnt == CW'(BIT_CLKS));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= TX_IDLE;
         cnt   <= '0;
         bitn  <= '0;
      end else begin
         cnt <= bit_tick ? '0 : cnt + CW'(1);
         case (state)
            TX_IDLE: begin
               cnt <= '0;
               if (i_start) state <= TX_START;   // start while busy is lost
            end
            TX_START: if (bit_tick) state <= TX_DATA;
            TX_DATA: if (bit_tick) begin
               bitn <= bitn + 3'd1;   // wraps back to 0 after bit 7
               if (bitn == 3'd7) state <= TX_STOP;
            end
            TX_STOP: if (bit_tick) state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) shreg <= i_data;
      else if (state == TX_DATA && bit_tick) shreg <= {1'b1, shreg[7:1]};
   end

   always_comb begin
      case (state)
         TX_START: o_uart_tx = 1'b0;
         TX_DATA:  o_uart_tx = shreg[0];
         default:  o_uart_tx = 1'b1;   // idle and stop
      endcase
   end

   assign o_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

//--- ice_code_ram.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_code_ram (
   input  wire                      i_clk,
   input  wire                      i_wr,
   input  wire [`ICE_CODE_AW-1:0]   i_waddr,
   input  wire [7:0]                i_wdata,
   input  wire [`ICE_CODE_AW-1:0]   i_raddr,
   output logic [7:0]               o_rdata
);

   logic [7:0] mem [`ICE_CODE_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wr) mem[i_waddr] <= i_wdata;   // loader side
   end

   // fetch side, same cycle
   assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

//--- ice_sequencer.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_sequencer import ice_pkg::*; (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  wire                      i_load_done,
   input  wire [7:0]                i_code_byte,
   input  wire                      i_take_branch,
   output logic [`ICE_CODE_AW-1:0]  o_pc,
   output logic                     o_exec,
   output op_e                      o_op,
   output logic [2:0]               o_reg_sel,
   output logic [7:0]               o_opnd1,
   output logic [7:0]               o_opnd2
);

   localparam int AW = `ICE_CODE_AW;

   seq_state_e       state;
   op_e              dec_op;
   logic [1:0]       dec_len;
   logic [1:0]       len_q;
   logic [AW-1:0]    pc;
   logic [AW-1:0]    rel_off;

   ////////////////////
   // decode

   always_comb begin
      casez (i_code_byte)
         8'h74:         dec_op = OP_MOV_A_IMM;
         8'b0111_1???:  dec_op = OP_MOV_R_IMM;
         8'b1110_1???:  dec_op = OP_MOV_A_R;
         8'b1111_1???:  dec_op = OP_MOV_R_A;
         8'h24:         dec_op = OP_ADD_A_IMM;
         8'b0010_1???:  dec_op = OP_ADD_A_R;
         8'b0011_1???:  dec_op = OP_ADDC_A_R;
         8'h94:         dec_op = OP_SUBB_A_IMM;
         8'b1001_1???:  dec_op = OP_SUBB_A_R;
         8'h54:         dec_op = OP_ANL_A_IMM;
         8'h44:         dec_op = OP_ORL_A_IMM;
         8'h64:         dec_op = OP_XRL_A_IMM;
         8'h04:         dec_op = OP_INC_A;
         8'h14:         dec_op = OP_DEC_A;
         8'b0000_1???:  dec_op = OP_INC_R;
         8'b0001_1???:  dec_op = OP_DEC_R;
         8'hF4:         dec_op = OP_CPL_A;
         8'hE4:         dec_op = OP_CLR_A;
         8'hC3:         dec_op = OP_CLR_C;
         8'hD3:         dec_op = OP_SETB_C;
         8'h23:         dec_op = OP_RL_A;
         8'h33:         dec_op = OP_RLC_A;
         8'h13:         dec_op = OP_RRC_A;
         8'hC4:         dec_op = OP_SWAP_A;
         8'h80:         dec_op = OP_SJMP;
         8'h60:         dec_op = OP_JZ;
         8'h70:         dec_op = OP_JNZ;
         8'h40:         dec_op = OP_JC;
         8'h50:         dec_op = OP_JNC;
         8'b1101_1???:  dec_op = OP_DJNZ_R;
         8'h90:         dec_op = OP_MOV_DPTR;
         8'hF0:         dec_op = OP_MOVX_W;
         8'hE0:         dec_op = OP_MOVX_R;
         default:       dec_op = OP_NOP;   // unknown opcodes run as one byte
      endcase
   end

   // instruction length in bytes
   always_comb begin
      case (dec_op)
         OP_MOV_A_IMM, OP_MOV_R_IMM, OP_ADD_A_IMM, OP_SUBB_A_IMM, OP_ANL_A_IMM,
         OP_ORL_A_IMM, OP_XRL_A_IMM, OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC,
         OP_DJNZ_R:     dec_len = 2'd2;
         OP_MOV_DPTR:   dec_len = 2'd3;
         default:       dec_len = 2'd1;
      endcase
   end

   ////////////////////
   // state and pc

   // offset is always the first operand for the kept branches
   assign rel_off = AW'($signed(o_opnd1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= FETCH;
         pc    <= '0;
         o_op  <= OP_NOP;
         len_q <= 2'd1;
      end else begin
         case (state)
            FETCH: if (i_load_done) state <= DECODE0;   // hold until code is in
            DECODE0: begin
               pc    <= pc + AW'(1);
               o_op  <= dec_op;
               len_q <= dec_len;
               state <= (dec_len == 2'd1) ? EXECUTE : DECODE1;
            end
            DECODE1: begin
               pc    <= pc + AW'(1);
               state <= (len_q == 2'd3) ? DECODE2 : EXECUTE;
            end
            DECODE2: begin
               pc    <= pc + AW'(1);
               state <= EXECUTE;
            end
            EXECUTE: begin
               if (i_take_branch) pc <= pc + rel_off;   // pc already past the instruction
               state <= FETCH;
            end
            default: state <= FETCH;
         endcase
      end
   end

   // operand latches
   always_ff @(posedge i_clk) begin
      if (state == DECODE0) o_reg_sel <= i_code_byte[2:0];
      if (state == DECODE1) o_opnd1 <= i_code_byte;
      if (state == DECODE2) o_opnd2 <= i_code_byte;
   end

   assign o_pc   = pc;
   assign o_exec = (state == EXECUTE);

endmodule

`default_nettype wire

//--- ice_datapath.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_datapath import ice_pkg::*; (
   input  wire          i_clk,
   input  wire          i_nrst,
   input  wire          i_exec,
   input  wire op_e     i_op,
   input  wire  [2:0]   i_reg_sel,
   input  wire  [7:0]   i_opnd1,
   input  wire  [7:0]   i_opnd2,
   input  wire          i_tx_busy,
   output logic         o_take_branch,
   output logic         o_tx_start,
   output logic [7:0]   o_tx_data
);

   localparam logic [15:0] TX_DATA_ADDR = `ICE_TX_DATA_ADDR;
   localparam logic [15:0] TX_STAT_ADDR = `ICE_TX_STAT_ADDR;

   logic [7:0]    acc;
   logic [7:0]    acc_nx;
   logic          cy;
   logic          cy_nx;
   logic [7:0]    rbank [8];   // r0..r7
   logic [15:0]   dptr;
   logic [7:0]    rdat;
   logic [7:0]    rdat_dec;
   logic [7:0]    alu_b;
   logic [8:0]    add_res;
   logic [8:0]    sub_res;
   logic          reg_we;
   logic [7:0]    reg_nx;
   logic          br;

   assign rdat     = rbank[i_reg_sel];
   assign rdat_dec = rdat - 8'd1;

   ////////////////////
   // alu

   assign alu_b   = (i_op == OP_ADD_A_IMM || i_op == OP_SUBB_A_IMM) ? i_opnd1 : rdat;
   assign add_res = {1'b0, acc} + {1'b0, alu_b} + {8'd0, (i_op == OP_ADDC_A_R) & cy};
   assign sub_res = {1'b0, acc} - {1'b0, alu_b} - {8'd0, cy};   // bit 8 is the borrow

   always_comb begin
      acc_nx = acc;
      cy_nx  = cy;
      reg_we = 1'b0;
      reg_nx = rdat;
      case (i_op)
         OP_MOV_A_IMM:  acc_nx = i_opnd1;
         OP_MOV_A_R:    acc_nx = rdat;
         OP_MOV_R_IMM: begin
            reg_we = 1'b1;
            reg_nx = i_opnd1;
         end
         OP_MOV_R_A: begin
            reg_we = 1'b1;
            reg_nx = acc;
         end
         OP_ADD_A_IMM, OP_ADD_A_R, OP_ADDC_A_R: {cy_nx, acc_nx} = add_res;
         OP_SUBB_A_IMM, OP_SUBB_A_R:            {cy_nx, acc_nx} = sub_res;
         OP_ANL_A_IMM:  acc_nx = acc & i_opnd1;
         OP_ORL_A_IMM:  acc_nx = acc | i_opnd1;
         OP_XRL_A_IMM:  acc_nx = acc ^ i_opnd1;
         OP_INC_A:      acc_nx = acc + 8'd1;   // carry untouched
         OP_DEC_A:      acc_nx = acc - 8'd1;
         OP_INC_R: begin
            reg_we = 1'b1;
            reg_nx = rdat + 8'd1;
         end
         OP_DEC_R, OP_DJNZ_R: begin
            reg_we = 1'b1;
            reg_nx = rdat_dec;
         end
         OP_CPL_A:      acc_nx = ~acc;
         OP_CLR_A:      acc_nx = 8'd0;
         OP_CLR_C:      cy_nx  = 1'b0;
         OP_SETB_C:     cy_nx  = 1'b1;
         OP_RL_A:       acc_nx = {acc[6:0], acc[7]};
         OP_RLC_A:      {cy_nx, acc_nx} = {acc, cy};
         OP_RRC_A:      {acc_nx, cy_nx} = {cy, acc};
         OP_SWAP_A:     acc_nx = {acc[3:0], acc[7:4]};
         OP_MOVX_R:     acc_nx = (dptr == TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'd0;
         default: ;
      endcase
   end

   ////////////////////
   // branch conditions

   always_comb begin
      case (i_op)
         OP_SJMP:    br = 1'b1;
         OP_JZ:      br = (acc == 8'd0);
         OP_JNZ:     br = (acc != 8'd0);
         OP_JC:      br = cy;
         OP_JNC:     br = ~cy;
         OP_DJNZ_R:  br = (rdat_dec != 8'd0);
         default:    br = 1'b0;
      endcase
   end

   assign o_take_branch = i_exec & br;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc  <= '0;
         cy   <= 1'b0;
         dptr <= '0;
         for (int i = 0; i < 8; i++) rbank[i] <= '0;
      end else if (i_exec) begin
         acc <= acc_nx;
         cy  <= cy_nx;
         if (reg_we) rbank[i_reg_sel] <= reg_nx;
         if (i_op == OP_MOV_DPTR) dptr <= {i_opnd1, i_opnd2};   // high byte first
      end
   end

   // movx write to the data address sends acc
   assign o_tx_start = i_exec & (i_op == OP_MOVX_W) & (dptr == TX_DATA_ADDR);
   assign o_tx_data  = acc;

endmodule

`default_nettype wire

//--- ice_top.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module ice_top import ice_pkg::*; (
   input  wire    i_clk,
   input  wire    i_nrst,
   input  wire    i_uart_rx,
   output logic   o_uart_tx
);

   logic                      code_wr;
   logic [`ICE_CODE_AW-1:0]   code_waddr;
   logic [7:0]                code_wdata;
   logic                      load_done;
   logic [`ICE_CODE_AW-1:0]   pc;
   logic [7:0]                code_byte;
   logic                      exec;
   op_e                       op;
   logic [2:0]                reg_sel;
   logic [7:0]                opnd1;
   logic [7:0]                opnd2;
   logic                      take_branch;
   logic                      tx_start;
   logic [7:0]                tx_data;
   logic                      tx_busy;

   ////////////////////
   // program load

   ice_uart_rx_loader loader_i (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_uart_rx     (i_uart_rx),
      .o_code_wr     (code_wr),
      .o_code_waddr  (code_waddr),
      .o_code_wdata  (code_wdata),
      .o_load_done   (load_done)
   );

   ice_code_ram code_ram_i (
      .i_clk   (i_clk),
      .i_wr    (code_wr),
      .i_waddr (code_waddr),
      .i_wdata (code_wdata),
      .i_raddr (pc),
      .o_rdata (code_byte)
   );

   ////////////////////
   // core

   ice_sequencer seq_i (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_load_done   (load_done),
      .i_code_byte   (code_byte),
      .i_take_branch (take_branch),
      .o_pc          (pc),
      .o_exec        (exec),
      .o_op          (op),
      .o_reg_sel     (reg_sel),
      .o_opnd1       (opnd1),
      .o_opnd2       (opnd2)
   );

   ice_datapath dp_i (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_exec        (exec),
      .i_op          (op),
      .i_reg_sel     (reg_sel),
      .i_opnd1       (opnd1),
      .i_opnd2       (opnd2),
      .i_tx_busy     (tx_busy),
      .o_take_branch (take_branch),
      .o_tx_start    (tx_start),
      .o_tx_data     (tx_data)
   );

   ice_uart_tx tx_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_start    (tx_start),
      .i_data     (tx_data),
      .o_busy     (tx_busy),
      .o_uart_tx  (o_uart_tx)
   );

endmodule

`default_nettype wire

//--- ice_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ice_asserts import ice_pkg::*; #(
   parameter bit SEQ_SIDE = 1'b1
) (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_exec,
   input  wire seq_state_e    i_seq_state,
   input  wire                i_load_done,
   input  wire tx_state_e     i_tx_state,
   input  wire                i_uart_tx
);

   if (SEQ_SIDE) begin : g_seq
      // execute is a single cycle pulse
      exec_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_exec |=> !i_exec)
         else $error("exec held high for more than one cycle");

      // no decode before the program is in
      no_early_decode: assert property (@(posedge i_clk) disable iff (!i_nrst)
         !(i_seq_state == DECODE0 && !i_load_done))
         else $error("sequencer left fetch before load_done");
   end else begin : g_tx
      tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
         (i_tx_state == TX_IDLE) |-> i_uart_tx)
         else $error("tx line low while transmitter idle");
   end

endmodule

bind ice_sequencer ice_asserts #(.SEQ_SIDE(1'b1)) seq_chk_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_exec        (o_exec),
   .i_seq_state   (state),
   .i_load_done   (i_load_done),
   .i_tx_state    (ice_pkg::TX_IDLE),
   .i_uart_tx     (1'b1)
);

bind ice_uart_tx ice_asserts #(.SEQ_SIDE(1'b0)) tx_chk_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_exec        (1'b0),
   .i_seq_state   (ice_pkg::FETCH),
   .i_load_done   (1'b1),
   .i_tx_state    (state),
   .i_uart_tx     (o_uart_tx)
);

`default_nettype wire

//--- tb_ice.sv
`timescale 1ns/1ps
`include "ice_config.svh"
`default_nettype none

module tb_ice;

   localparam int BIT_CLKS = `ICE_CLKS_PER_BIT;
   localparam int DEPTH    = `ICE_CODE_DEPTH;
   localparam logic [15:0] STAT_ADDR = `ICE_TX_STAT_ADDR;
   localparam logic [15:0] DATA_ADDR = `ICE_TX_DATA_ADDR;

   logic i_clk;
   logic i_nrst;
   logic i_uart_rx;
   wire  o_uart_tx;

   logic [31:0]   lfsr;
   logic [7:0]    prog [DEPTH];
   int            emit_tag [DEPTH];   // 1 alu, 2 regs, 3 branch
   int            pos;
   logic [7:0]    exp_q [$];
   int            tag_q [$];
   int            chk [6];
   int            err [6];
   string         tname [6];
   int            rcv;
   bit            idle_bad;

   ice_top ice_top_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_uart_rx  (i_uart_rx),
      .o_uart_tx  (o_uart_tx)
   );

   always #50 i_clk = ~i_clk;

   // line must stay idle until the core starts
   always @(negedge i_clk) begin
      if (i_nrst && ice_top_i.load_done === 1'b0 && o_uart_tx !== 1'b1) begin
         if (!idle_bad) $display("tx line dropped low while the program was loading");
         idle_bad = 1'b1;
      end
   end

   ////////////////////
   // random program

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   task automatic put_byte(input logic [7:0] b);
      prog[pos] = b;
      pos++;
   endtask

   // opcode followed by a random immediate
   task automatic put_imm(input logic [7:0] opc);
      put_byte(opc);
      put_byte(8'(rand_bits(8)));
   endtask

   // save acc, poll busy, restore acc, write data register
   task automatic put_emit(input int tag);
      put_byte(8'hFF);
      put_byte(8'h90);
      put_byte(STAT_ADDR[15:8]);
      put_byte(STAT_ADDR[7:0]);
      put_byte(8'hE0);
      put_byte(8'h70);
      put_byte(8'hFD);   // back to the movx read
      put_byte(8'hEF);
      put_byte(8'h90);
      put_byte(DATA_ADDR[15:8]);
      put_byte(DATA_ADDR[7:0]);
      emit_tag[pos] = tag;
      put_byte(8'hF0);
   endtask

   task automatic alu_block();
      int n;
      logic [7:0] r;
      n = 3 + rand_bits(1);
      for (int i = 0; i < n; i++) begin
         r = 8'(rand_bits(3) % 7);
         case (rand_bits(4))
            0:  put_imm(8'h74);
            1:  put_imm(8'h24);
            2:  put_byte(8'h28 + r);
            3:  put_byte(8'h38 + r);
            4:  put_imm(8'h94);
            5:  put_byte(8'h98 + r);
            6:  put_imm(8'h54);
            7:  put_imm(8'h44);
            8:  put_imm(8'h64);
            9:  put_byte(rand_bits(1) ? 8'h04 : 8'h14);
            10: put_byte(rand_bits(1) ? 8'hF4 : 8'hE4);
            11: put_byte(rand_bits(1) ? 8'hD3 : 8'hC3);
            12: put_byte(8'h23);
            13: put_byte(8'h33);
            14: put_byte(8'h13);
            default: put_byte(8'hC4);
         endcase
      end
      put_emit(1);
   endtask

   task automatic reg_block();
      int n;
      logic [7:0] r;
      n = 2 + rand_bits(1);
      for (int i = 0; i < n; i++) begin
         r = 8'(rand_bits(3) % 7);
         case (rand_bits(2))
            0: put_imm(8'h78 + r);
            1: put_byte(8'h08 + r);
            2: put_byte(8'h18 + r);
            default: begin
               put_byte(8'h78 + r);   // short counted loop
               put_byte(8'(1 + rand_bits(2)));
               put_byte(8'h04);
               put_byte(8'hD8 + r);
               put_byte(8'hFD);
            end
         endcase
      end
      put_byte(8'hE8 + r);
      put_emit(2);
   endtask

   task automatic branch_block();
      logic [7:0] conds [4];
      logic [7:0] mark;
      conds = '{8'h60, 8'h70, 8'h40, 8'h50};
      put_byte(conds[rand_bits(2)]);
      put_byte(8'd16);   // over the fall-through marker
      mark = 8'(rand_bits(8));
      put_byte(8'h74);
      put_byte(mark);
      put_emit(3);
      put_byte(8'h80);
      put_byte(8'd14);
      put_byte(8'h74);
      put_byte(~mark);   // taken path marker never equals the other one
      put_emit(3);
   endtask

   task automatic build_program();
      pos = 0;
      for (int i = 0; i < DEPTH; i++) begin
         prog[i] = 8'h00;
         emit_tag[i] = 0;
      end
      while (pos < DEPTH - 40) begin
         case (rand_bits(2))
            1: reg_block();
            2: branch_block();
            default: alu_block();
         endcase
      end
      put_byte(8'h80);
      put_byte(8'hFE);   // park here
   endtask

   ////////////////////
   // instruction set model

   task automatic run_model();
      logic [7:0] a, op, b1, nxt;
      logic [7:0] r [8];
      logic [7:0] pc;
      logic [15:0] dptr;
      logic c, br;
      int len, steps;
      a = 8'd0;
      c = 1'b0;
      dptr = 16'd0;
      pc = 8'd0;
      steps = 0;
      for (int i = 0; i < 8; i++) r[i] = 8'd0;
      forever begin
         op = prog[pc];
         b1 = prog[8'(pc + 8'd1)];
         if (op == 8'h80 && b1 == 8'hFE) break;
         steps++;
         if (steps > 20000) begin
            $display("model did not reach the end of the program");
            err[5]++;
            break;
         end
         casez (op)
            8'h74, 8'h24, 8'h94, 8'h54, 8'h44, 8'h64, 8'h80, 8'h60, 8'h70, 8'h40,
            8'h50, 8'b0111_1???, 8'b1101_1???: len = 2;
            8'h90: len = 3;
            default: len = 1;
         endcase
         nxt = pc + 8'(len);
         br = 1'b0;
         casez (op)
            8'h74: a = b1;
            8'b0111_1???: r[op[2:0]] = b1;
            8'b1110_1???: a = r[op[2:0]];
            8'b1111_1???: r[op[2:0]] = a;
            8'h24: {c, a} = {1'b0, a} + {1'b0, b1};
            8'b0010_1???: {c, a} = {1'b0, a} + {1'b0, r[op[2:0]]};
            8'b0011_1???: {c, a} = {1'b0, a} + {1'b0, r[op[2:0]]} + {8'd0, c};
            8'h94: {c, a} = {1'b0, a} - {1'b0, b1} - {8'd0, c};
            8'b1001_1???: {c, a} = {1'b0, a} - {1'b0, r[op[2:0]]} - {8'd0, c};
            8'h54: a = a & b1;
            8'h44: a = a | b1;
            8'h64: a = a ^ b1;
            8'h04: a = a + 8'd1;
            8'h14: a = a - 8'd1;
            8'b0000_1???: r[op[2:0]] = r[op[2:0]] + 8'd1;
            8'b0001_1???: r[op[2:0]] = r[op[2:0]] - 8'd1;
            8'hF4: a = ~a;
            8'hE4: a = 8'd0;
            8'hC3: c = 1'b0;
            8'hD3: c = 1'b1;
            8'h23: a = {a[6:0], a[7]};
            8'h33: {c, a} = {a, c};
            8'h13: {a, c} = {c, a};
            8'hC4: a = {a[3:0], a[7:4]};
            8'h80: br = 1'b1;
            8'h60: br = (a == 8'd0);
            8'h70: br = (a != 8'd0);
            8'h40: br = c;
            8'h50: br = !c;
            8'b1101_1???: begin
               r[op[2:0]] = r[op[2:0]] - 8'd1;
               br = (r[op[2:0]] != 8'd0);
            end
            8'h90: dptr = {b1, prog[8'(pc + 8'd2)]};
            8'hF0: if (dptr == DATA_ADDR) begin
               exp_q.push_back(a);
               tag_q.push_back(emit_tag[pc]);
            end
            8'hE0: a = 8'd0;   // transmitter seen as never busy
            default: ;
         endcase
         pc = br ? nxt + b1 : nxt;
      end
   endtask

   ////////////////////
   // uart driver and monitor

   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int k = 0; k < 10; k++) begin
         @(posedge i_clk);
         i_uart_rx <= frame[k];
         repeat (BIT_CLKS) @(posedge i_clk);
      end
   endtask

   task automatic send_program();
      for (int i = 0; i < DEPTH; i++) send_byte(prog[i]);
   endtask

   task automatic recv_byte(input int limit, output bit got, output logic [7:0] d,
                            output bit stop_ok);
      int n;
      n = 0;
      got = 1'b0;
      stop_ok = 1'b0;
      d = 8'd0;
      while (o_uart_tx !== 1'b0 && n < limit) begin
         @(negedge i_clk);
         n++;
      end
      if (o_uart_tx !== 1'b0) return;
      repeat (BIT_CLKS / 2) @(negedge i_clk);   // middle of start bit
      for (int k = 0; k < 8; k++) begin
         repeat (BIT_CLKS + 1) @(negedge i_clk);
         d[k] = o_uart_tx;
      end
      repeat (BIT_CLKS + 1) @(negedge i_clk);
      stop_ok = (o_uart_tx === 1'b1);
      got = 1'b1;
   endtask

   task automatic receive_all();
      bit got, sok;
      logic [7:0] d;
      int tg;
      for (int i = 0; i < exp_q.size(); i++) begin
         recv_byte(i == 0 ? 400000 : 40000, got, d, sok);
         if (!got) begin
            $display("timed out waiting for tx byte %0d of %0d", i, exp_q.size());
            err[5]++;
            break;
         end
         rcv++;
         tg = tag_q[i];
         chk[tg]++;
         if (d !== exp_q[i]) begin
            $display("CHECK FAILED %s: expected 0x%02h, actual 0x%02h", tname[tg], exp_q[i], d);
            err[tg]++;
         end
         chk[4]++;
         if (!sok) begin
            $display("stop bit of tx byte %0d was low", i);
            err[4]++;
         end
      end
      recv_byte(5000, got, d, sok);
      if (got) begin
         $display("an extra tx byte 0x%02h arrived after the expected ones", d);
         err[5]++;
      end
      chk[5]++;
      if (rcv != exp_q.size()) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", tname[5], exp_q.size(), rcv);
         err[5]++;
      end
   endtask

   initial begin
      int total_chk, total_err;
      i_clk = 1'b0;
      i_nrst = 1'b0;
      i_uart_rx = 1'b1;
      lfsr = 32'd74187;
      idle_bad = 1'b0;
      rcv = 0;
      tname = '{"idle", "alu", "regs", "branch", "framing", "completion"};
      for (int i = 0; i < 6; i++) begin
         chk[i] = 0;
         err[i] = 0;
      end
      build_program();
      run_model();
      repeat (10) @(posedge i_clk);
      i_nrst <= 1'b1;
      repeat (5) @(posedge i_clk);
      fork
         send_program();
         receive_all();
      join
      chk[0] = 1;
      err[0] = int'(idle_bad);
      total_chk = 0;
      total_err = 0;
      for (int i = 0; i < 6; i++) begin
         $display("test %s: %0d checks, %0d errors", tname[i], chk[i], err[i]);
         total_chk += chk[i];
         total_err += err[i];
      end
      $display("total: %0d checks, %0d errors", total_chk, total_err);
      if (total_err == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
ice_pkg.sv
ice_uart_rx_loader.sv
ice_uart_tx.sv
ice_code_ram.sv
ice_sequencer.sv
ice_datapath.sv
ice_top.sv
ice_asserts.sv
tb_ice.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ice -f sim.f -o vsim
	out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
